// File: hdl/maskPkg.sv
// Masked S-box shared definitions
package maskPkg;

    // GF(2^4) element, polynomial basis modulo x^4 + x + 1
    typedef logic [3:0] gf4T;

    localparam logic [7:0] sboxAffineConst = 8'h63;
    localparam int sboxLatency = 5;

    // Norm scaling constant nu, root of y^2 + y + nu spans GF(2^8)
    localparam gf4T sqScConst = 4'h8;

    // AES bit k to tower byte, column k at index k
    localparam logic [7:0][7:0] mapInCols = {
        8'h5e, 8'hd8, 8'hb5, 8'h14, 8'h47, 8'hcf, 8'h62, 8'h11
    };

    // Tower bit k to affine-transformed AES byte
    localparam logic [7:0][7:0] mapOutCols = {
        8'hec, 8'h8a, 8'h28, 8'hc9, 8'h68, 8'h38, 8'h9c, 8'hd6
    };

    // Four fresh bits per share pair
    function automatic int domRandBits(input int shares);
        return 2 * shares * (shares - 1);
    endfunction

    // Pair {i,j} position in the randomness vector, pairs in row order
    function automatic int pairIdx(input int shares, input int i, input int j);
        int lo;
        int hi;
        lo = (i < j) ? i : j;
        hi = (i < j) ? j : i;
        return lo * (2 * shares - lo - 1) / 2 + (hi - lo - 1);
    endfunction

    function automatic gf4T gf4Mul(input gf4T a, input gf4T b);
        logic [6:0] prod;
        prod = '0;
        for (int k = 0; k < 4; k++) begin
            if (b[k]) begin
                prod ^= 7'(a) << k;
            end
        end
        // Fold x^6..x^4 back with x^4 = x + 1
        for (int k = 6; k >= 4; k--) begin
            if (prod[k]) begin
                prod ^= 7'b0010011 << (k - 4);
            end
        end
        return prod[3:0];
    endfunction

    function automatic gf4T gf4Sq(input gf4T a);
        return {a[3], a[3] ^ a[1], a[2], a[2] ^ a[0]};
    endfunction

    function automatic gf4T gf4SqSc(input gf4T a);
        return gf4Mul(gf4Sq(a), sqScConst);
    endfunction

    // Sum of the columns selected by x
    function automatic logic [7:0] mulCols8(input logic [7:0][7:0] cols, input logic [7:0] x);
        logic [7:0] acc;
        acc = '0;
        for (int k = 0; k < 8; k++) begin
            if (x[k]) begin
                acc ^= cols[k];
            end
        end
        return acc;
    endfunction

    // High nibble is the coefficient of W^16, low nibble of W
    function automatic logic [7:0] linMapIn(input logic [7:0] x);
        return mulCols8(mapInCols, x);
    endfunction

    // Back to the AES basis with the affine matrix folded in
    function automatic logic [7:0] linMapOut(input logic [7:0] t);
        return mulCols8(mapOutCols, t);
    endfunction

endpackage

// File: hdl/sboxRandIf.sv
// S-box fresh randomness bundle
interface sboxRandIf #(
    parameter int Shares = 2
);
    localparam int RandBits = maskPkg::domRandBits(Shares);

    // Outer multiplications
    logic [RandBits-1:0] zSqSc;
    logic [RandBits-1:0] zMsb;
    logic [RandBits-1:0] zLsb;

    // Inverter multiplications and refresh
    logic [RandBits-1:0] zInvA;
    logic [RandBits-1:0] zInvB;
    logic [RandBits-1:0] zInvRef;

    modport source (
        output zSqSc, zMsb, zLsb, zInvA, zInvB, zInvRef
    );

    modport sink (
        input zSqSc, zMsb, zLsb, zInvA, zInvB, zInvRef
    );

endinterface

// File: hdl/domMulGf4.sv
// DOM multiplier in GF(2^4)
module domMulGf4 #(
    parameter int Shares = 2,
    parameter bit SqSc = 1'b0
) (
    input  logic                                    ClkxCI,
    input  logic [4*Shares-1:0]                     XShares,
    input  logic [4*Shares-1:0]                     YShares,
    input  logic [maskPkg::domRandBits(Shares)-1:0] Z,
    output logic [4*Shares-1:0]                     QShares
);

    for (genvar i = 0; i < Shares; i++) begin : gDomain
        maskPkg::gf4T termD [Shares];
        maskPkg::gf4T termQ [Shares];
        maskPkg::gf4T sumQ;

        // Inner term at j == i, blinded cross terms elsewhere
        always_comb begin
            for (int j = 0; j < Shares; j++) begin
                if (j == i) begin
                    termD[j] = maskPkg::gf4Mul(XShares[4*i +: 4], YShares[4*i +: 4]);
                    if (SqSc) begin
                        // Linear term stays inside its own domain
                        termD[j] ^= maskPkg::gf4SqSc(XShares[4*i +: 4] ^ YShares[4*i +: 4]);
                    end
                end else begin
                    // Same nibble on both sides of the pair, cancels in the sum
                    termD[j] = maskPkg::gf4Mul(XShares[4*i +: 4], YShares[4*j +: 4])
                             ^ Z[4*maskPkg::pairIdx(Shares, i, j) +: 4];
                end
            end
        end

        // Register before any recombination
        always_ff @(posedge ClkxCI) begin
            termQ <= termD;
        end

        always_comb begin
            sumQ = '0;
            for (int j = 0; j < Shares; j++) begin
                sumQ ^= termQ[j];
            end
        end

        assign QShares[4*i +: 4] = sumQ;
    end

endmodule

// File: hdl/gf4Inverter.sv
// Shared GF(2^4) inverter
module gf4Inverter #(
    parameter int Shares = 2
) (
    input  logic                ClkxCI,
    input  logic [4*Shares-1:0] XShares,
    sboxRandIf.sink             rnd,
    output logic [4*Shares-1:0] QShares
);

    logic [4*Shares-1:0] xRefreshed;
    logic [4*Shares-1:0] xSquared;
    logic [4*Shares-1:0] xSquaredQ;
    logic [4*Shares-1:0] xCubed;
    logic [4*Shares-1:0] xTwelfth;

    // Fresh sharing of x for the x^2 * x product
    always_comb begin
        xRefreshed = XShares;
        for (int i = 0; i < Shares; i++) begin
            for (int j = i + 1; j < Shares; j++) begin
                xRefreshed[4*i +: 4] ^= rnd.zInvRef[4*maskPkg::pairIdx(Shares, i, j) +: 4];
                xRefreshed[4*j +: 4] ^= rnd.zInvRef[4*maskPkg::pairIdx(Shares, i, j) +: 4];
            end
        end
    end

    // Squaring is linear, done share by share
    for (genvar i = 0; i < Shares; i++) begin : gSquare
        assign xSquared[4*i +: 4] = maskPkg::gf4Sq(XShares[4*i +: 4]);
        assign xTwelfth[4*i +: 4] = maskPkg::gf4Sq(maskPkg::gf4Sq(xCubed[4*i +: 4]));
    end

    // x^3 after one cycle
    domMulGf4 #(
        .Shares(Shares),
        .SqSc  (1'b0)
    ) mulCube (
        .ClkxCI (ClkxCI),
        .XShares(xSquared),
        .YShares(xRefreshed),
        .Z      (rnd.zInvA),
        .QShares(xCubed)
    );

    // Keep x^2 aligned with x^3
    always_ff @(posedge ClkxCI) begin
        xSquaredQ <= xSquared;
    end

    // x^12 * x^2 = x^14, maps 0 to 0
    domMulGf4 #(
        .Shares(Shares),
        .SqSc  (1'b0)
    ) mulInverse (
        .ClkxCI (ClkxCI),
        .XShares(xTwelfth),
        .YShares(xSquaredQ),
        .Z      (rnd.zInvB),
        .QShares(QShares)
    );

endmodule

// File: hdl/maskedSbox.sv
// Five-stage masked AES S-box datapath
module maskedSbox #(
    parameter int Shares = 2
) (
    input  logic                ClkxCI,
    input  logic [8*Shares-1:0] XShares,
    sboxRandIf.sink             rnd,
    output logic [8*Shares-1:0] QShares
);

    logic [8*Shares-1:0] mappedQ;
    logic [4*Shares-1:0] y1Shares;
    logic [4*Shares-1:0] y0Shares;
    logic [4*Shares-1:0] y1Delay [3];
    logic [4*Shares-1:0] y0Delay [3];
    logic [4*Shares-1:0] normShares;
    logic [4*Shares-1:0] invShares;
    logic [4*Shares-1:0] invHigh;
    logic [4*Shares-1:0] invLow;

    // Stage 1, basis change into the tower field
    always_ff @(posedge ClkxCI) begin
        for (int i = 0; i < Shares; i++) begin
            mappedQ[8*i +: 8] <= maskPkg::linMapIn(XShares[8*i +: 8]);
        end
    end

    for (genvar i = 0; i < Shares; i++) begin : gSplit
        assign y1Shares[4*i +: 4] = mappedQ[8*i+4 +: 4];
        assign y0Shares[4*i +: 4] = mappedQ[8*i +: 4];
    end

    // Y1 and Y0 wait for the inverse
    always_ff @(posedge ClkxCI) begin
        y1Delay[0] <= y1Shares;
        y0Delay[0] <= y0Shares;
        for (int k = 1; k < 3; k++) begin
            y1Delay[k] <= y1Delay[k-1];
            y0Delay[k] <= y0Delay[k-1];
        end
    end

    // Stage 2, norm nu*(Y1+Y0)^2 + Y1*Y0
    domMulGf4 #(
        .Shares(Shares),
        .SqSc  (1'b1)
    ) mulSqSc (
        .ClkxCI (ClkxCI),
        .XShares(y1Shares),
        .YShares(y0Shares),
        .Z      (rnd.zSqSc),
        .QShares(normShares)
    );

    // Stages 3 and 4
    gf4Inverter #(
        .Shares(Shares)
    ) inverter (
        .ClkxCI (ClkxCI),
        .XShares(normShares),
        .rnd    (rnd),
        .QShares(invShares)
    );

    // Stage 5, the two halves of the GF(2^8) inverse
    domMulGf4 #(
        .Shares(Shares),
        .SqSc  (1'b0)
    ) mulMsb (
        .ClkxCI (ClkxCI),
        .XShares(invShares),
        .YShares(y0Delay[2]),
        .Z      (rnd.zMsb),
        .QShares(invHigh)
    );

    domMulGf4 #(
        .Shares(Shares),
        .SqSc  (1'b0)
    ) mulLsb (
        .ClkxCI (ClkxCI),
        .XShares(invShares),
        .YShares(y1Delay[2]),
        .Z      (rnd.zLsb),
        .QShares(invLow)
    );

    // Output map per share, affine constant on share 0 only
    always_comb begin
        logic [7:0] outByte;
        for (int i = 0; i < Shares; i++) begin
            outByte = maskPkg::linMapOut({invHigh[4*i +: 4], invLow[4*i +: 4]});
            if (i == 0) begin
                outByte ^= maskPkg::sboxAffineConst;
            end
            QShares[8*i +: 8] = outByte;
        end
    end

endmodule

// File: hdl/maskedSboxTop.sv
// Masked S-box top level
module maskedSboxTop #(
    parameter int Shares = 2
) (
    input  logic                                    ClkxCI,
    input  logic                                    rst,
    input  logic                                    InValid,
    input  logic [8*Shares-1:0]                     XShares,
    input  logic [maskPkg::domRandBits(Shares)-1:0] ZSqSc,
    input  logic [maskPkg::domRandBits(Shares)-1:0] ZMsb,
    input  logic [maskPkg::domRandBits(Shares)-1:0] ZLsb,
    input  logic [maskPkg::domRandBits(Shares)-1:0] ZInvA,
    input  logic [maskPkg::domRandBits(Shares)-1:0] ZInvB,
    input  logic [maskPkg::domRandBits(Shares)-1:0] ZInvRef,
    output logic                                    OutValid,
    output logic [8*Shares-1:0]                     QShares
);

    localparam int Latency = maskPkg::sboxLatency;

    logic [Latency-1:0] validPipe;

    sboxRandIf #(
        .Shares(Shares)
    ) rndIf ();

    assign rndIf.zSqSc   = ZSqSc;
    assign rndIf.zMsb    = ZMsb;
    assign rndIf.zLsb    = ZLsb;
    assign rndIf.zInvA   = ZInvA;
    assign rndIf.zInvB   = ZInvB;
    assign rndIf.zInvRef = ZInvRef;

    maskedSbox #(
        .Shares(Shares)
    ) sbox (
        .ClkxCI (ClkxCI),
        .XShares(XShares),
        .rnd    (rndIf),
        .QShares(QShares)
    );

    // Strobe follows the data through all stages
    always_ff @(posedge ClkxCI) begin
        if (rst) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[Latency-2:0], InValid};
        end
    end

    assign OutValid = validPipe[Latency-1];

endmodule

// File: tb/maskedSbox_assertions.sv
// Masked S-box timing assertions
module maskedSbox_assertions #(
    parameter int Shares = 2
) (
    input logic                                    ClkxCI,
    input logic                                    rst,
    input logic                                    InValid,
    input logic                                    OutValid,
    input logic [maskPkg::domRandBits(Shares)-1:0] ZSqSc,
    input logic [maskPkg::domRandBits(Shares)-1:0] ZMsb,
    input logic [maskPkg::domRandBits(Shares)-1:0] ZLsb,
    input logic [maskPkg::domRandBits(Shares)-1:0] ZInvA,
    input logic [maskPkg::domRandBits(Shares)-1:0] ZInvB,
    input logic [maskPkg::domRandBits(Shares)-1:0] ZInvRef
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int Latency = 5;

    // Edges since reset left, saturating
    logic [2:0] settled;

    always_ff @(posedge ClkxCI) begin
        if (rst) begin
            settled <= '0;
        end else if (settled < 3'(Latency)) begin
            settled <= settled + 3'd1;
        end
    end

    validDelay: assert property (
        @(posedge ClkxCI) (settled == 3'(Latency)) |-> (OutValid == $past(InValid, Latency))
    ) else $error("OutValid does not follow InValid by %0d cycles", Latency);

    // Cleared by every reset edge
    resetClear: assert property (
        @(posedge ClkxCI) $past(rst) |-> !OutValid
    ) else $error("OutValid high while in reset");

    randKnown: assert property (
        @(posedge ClkxCI) InValid |-> !$isunknown({ZSqSc, ZMsb, ZLsb, ZInvA, ZInvB, ZInvRef})
    ) else $error("randomness input unknown while InValid is high");

endmodule

bind maskedSboxTop maskedSbox_assertions #(
    .Shares(Shares)
) assertions (
    .ClkxCI  (ClkxCI),
    .rst     (rst),
    .InValid (InValid),
    .OutValid(OutValid),
    .ZSqSc   (ZSqSc),
    .ZMsb    (ZMsb),
    .ZLsb    (ZLsb),
    .ZInvA   (ZInvA),
    .ZInvB   (ZInvB),
    .ZInvRef (ZInvRef)
);

// File: tb/maskedSboxTb.sv
// Masked S-box testbench
module maskedSboxTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int Shares = 2;
    localparam int RandBits = 4 * Shares * (Shares - 1) / 2;
    localparam int Latency = 5;
    localparam int ClkPeriod = 100;
    localparam int NumEntries = 24;
    localparam int DrainSteps = Latency + 2;

    // Entry modes
    localparam logic [1:0] ModeRandom = 2'd0;
    localparam logic [1:0] ModeZero = 2'd1;
    localparam logic [1:0] ModeBubble = 2'd2;

    typedef struct packed {
        logic [7:0] x;
        logic [7:0] sbox;
        logic [1:0] mode;
    } entryT;

    typedef struct packed {
        int unsigned due;
        logic [7:0]  sbox;
        logic        zeroCase;
    } expectT;

    logic                ClkxCI = 1'b0;
    logic                rst;
    logic                InValid;
    logic [8*Shares-1:0] XShares;
    logic [RandBits-1:0] ZSqSc;
    logic [RandBits-1:0] ZMsb;
    logic [RandBits-1:0] ZLsb;
    logic [RandBits-1:0] ZInvA;
    logic [RandBits-1:0] ZInvB;
    logic [RandBits-1:0] ZInvRef;
    logic                OutValid;
    logic [8*Shares-1:0] QShares;

    // Unmasked byte, FIPS-197 S-box value and mode
    entryT stimTable [NumEntries] = '{
        '{8'h00, 8'h63, ModeRandom},
        '{8'h01, 8'h7c, ModeRandom},
        '{8'h53, 8'hed, ModeRandom},
        '{8'hff, 8'h16, ModeRandom},
        '{8'h00, 8'h63, ModeZero},
        '{8'h10, 8'hca, ModeRandom},
        '{8'h11, 8'h82, ModeRandom},
        '{8'h02, 8'h77, ModeRandom},
        '{8'h53, 8'hed, ModeRandom},
        '{8'h00, 8'h00, ModeBubble},
        '{8'h80, 8'hcd, ModeRandom},
        '{8'h8f, 8'h73, ModeRandom},
        '{8'hc9, 8'hdd, ModeRandom},
        '{8'h53, 8'hed, ModeZero},
        '{8'h3c, 8'heb, ModeRandom},
        '{8'h00, 8'h00, ModeBubble},
        '{8'h00, 8'h00, ModeBubble},
        '{8'ha5, 8'h06, ModeRandom},
        '{8'h7e, 8'hf3, ModeRandom},
        '{8'hff, 8'h16, ModeZero},
        '{8'h01, 8'h7c, ModeRandom},
        '{8'h6a, 8'h02, ModeRandom},
        '{8'h00, 8'h00, ModeBubble},
        '{8'h4c, 8'h29, ModeRandom}
    };

    expectT      expQ [$];
    int unsigned cycleCnt = 0;
    int          seed = 18145;

    maskedSboxTop #(
        .Shares(Shares)
    ) dut (
        .ClkxCI  (ClkxCI),
        .rst     (rst),
        .InValid (InValid),
        .XShares (XShares),
        .ZSqSc   (ZSqSc),
        .ZMsb    (ZMsb),
        .ZLsb    (ZLsb),
        .ZInvA   (ZInvA),
        .ZInvB   (ZInvB),
        .ZInvRef (ZInvRef),
        .OutValid(OutValid),
        .QShares (QShares)
    );

    always #(ClkPeriod / 2) ClkxCI = ~ClkxCI;

    always @(posedge ClkxCI) begin
        cycleCnt <= cycleCnt + 1;
    end

    task automatic stopOnFailure(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkVal(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected) begin
            stopOnFailure($sformatf("error at %0d ns: %s is 0x%0h, expected 0x%0h",
                                    $time, name, actual, expected));
        end
    endtask

    // Share 0 closes the sum of the random upper shares to x
    function automatic logic [8*Shares-1:0] maskByte(input logic [7:0] x, input logic useMasks);
        logic [8*Shares-1:0] shares;
        logic [7:0]          sum;
        shares = '0;
        sum = x;
        for (int i = 1; i < Shares; i++) begin
            if (useMasks) begin
                shares[8*i +: 8] = 8'($random(seed));
            end
            sum ^= shares[8*i +: 8];
        end
        shares[7:0] = sum;
        return shares;
    endfunction

    function automatic logic [7:0] unmaskByte(input logic [8*Shares-1:0] shares);
        logic [7:0] sum;
        sum = '0;
        for (int i = 0; i < Shares; i++) begin
            sum ^= shares[8*i +: 8];
        end
        return sum;
    endfunction

    function automatic logic [RandBits-1:0] freshBits(input logic zeroRnd);
        return zeroRnd ? '0 : RandBits'($random(seed));
    endfunction

    task automatic driveRandomness(input logic zeroRnd);
        ZSqSc <= freshBits(zeroRnd);
        ZMsb <= freshBits(zeroRnd);
        ZLsb <= freshBits(zeroRnd);
        ZInvA <= freshBits(zeroRnd);
        ZInvB <= freshBits(zeroRnd);
        ZInvRef <= freshBits(zeroRnd);
    endtask

    initial begin
        int     zeroUntil;
        entryT  ent;
        expectT expItem;
        rst = 1'b1;
        InValid = 1'b0;
        XShares = '0;
        ZSqSc = '0;
        ZMsb = '0;
        ZLsb = '0;
        ZInvA = '0;
        ZInvB = '0;
        ZInvRef = '0;
        zeroUntil = -1;

        repeat (3) @(posedge ClkxCI);
        rst <= 1'b0;

        // One entry per cycle and then bubbles to drain the pipeline
        for (int idx = 0; idx < NumEntries + DrainSteps; idx++) begin
            @(posedge ClkxCI);
            if (idx < NumEntries) begin
                ent = stimTable[idx];
            end else begin
                ent = '{8'h00, 8'h00, ModeBubble};
            end
            // Zero sharing needs zero randomness in every later stage too
            if (ent.mode == ModeZero) begin
                zeroUntil = idx + Latency - 1;
            end
            driveRandomness(idx <= zeroUntil);
            InValid <= (ent.mode != ModeBubble);
            XShares <= maskByte(ent.x, ent.mode == ModeRandom);
            if (ent.mode != ModeBubble) begin
                // Sampled at the next edge while the counter also steps at this one
                expItem.due = cycleCnt + Latency + 1;
                expItem.sbox = ent.sbox;
                expItem.zeroCase = (ent.mode == ModeZero);
                expQ.push_back(expItem);
            end
        end

        @(negedge ClkxCI);
        if (expQ.size() != 0) begin
            stopOnFailure($sformatf("%0d expected results never came out", expQ.size()));
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

    // Outputs are read at the falling edge where they are stable
    always @(negedge ClkxCI) begin
        expectT head;
        if (OutValid === 1'b1) begin
            if (expQ.size() == 0) begin
                stopOnFailure("OutValid went high while no byte was in flight");
            end else begin
                head = expQ.pop_front();
                checkVal("OutValid arrival cycle", 32'(cycleCnt), 32'(head.due));
                if (head.zeroCase) begin
                    checkVal("QShares[7:0]", 32'(QShares[7:0]), 32'(head.sbox));
                    for (int i = 1; i < Shares; i++) begin
                        checkVal($sformatf("QShares[%0d:%0d]", 8*i+7, 8*i),
                                 32'(QShares[8*i +: 8]), 32'd0);
                    end
                end else begin
                    checkVal("unmasked QShares", 32'(unmaskByte(QShares)), 32'(head.sbox));
                end
            end
        end else begin
            checkVal("OutValid", 32'(OutValid), 32'd0);
        end
    end

    // Twice the table length plus margin
    initial begin
        #((NumEntries + 20) * ClkPeriod * 2);
        stopOnFailure("watchdog timeout because the run did not finish in time");
    end

endmodule

// File: flist.f
hdl/maskPkg.sv
hdl/sboxRandIf.sv
hdl/domMulGf4.sv
hdl/gf4Inverter.sv
hdl/maskedSbox.sv
hdl/maskedSboxTop.sv
tb/maskedSbox_assertions.sv
tb/maskedSboxTb.sv

// File: Makefile
# Verilator build and run of the masked S-box testbench

TOP = maskedSboxTb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	rm -f $(LOG)
	-verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -Mdir obj_dir -f flist.f > $(LOG) 2>&1 && \
		./obj_dir/V$(TOP) >> $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "Build or run did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
